// File: verilog/mole_macros.svh
`ifndef MOLE_MACROS_SVH
`define MOLE_MACROS_SVH

////////////////////
// Grid geometry
`define GRID_COLS   4
`define GRID_ROWS   3
`define CELL_PITCH  160  // Pixels between cell corners
`define CELL_OFFSET 40   // Corner of the first cell
`define TARGET_SIZE 80   // Side of a square target

////////////////////
// Round timing, in clock cycles
`define ROUND_BASE 255  // Round length at level 0
`define ROUND_MIN  16   // Shortest round at high levels

////////////////////
// Score rules
`define LEVEL_UP_SCORE     15
`define PAIR_REWARD        2
`define SINGLE_REWARD      1
`define DECOY_PAIR_PENALTY 4
`define DECOY_PENALTY      5

`define LFSR_SEED_X 31'h1555_5555  // Any nonzero seed works
`define LFSR_SEED_Y 29'h1555_5555
`endif

// File: verilog/mole_pkg.sv
package mole_pkg;

  // Pixel coordinates of pointer and target corners
  typedef logic [9:0] coord_x_t;  // Horizontal, up to 1023
  typedef logic [8:0] coord_y_t;  // Vertical, up to 511

  // Column or row number on the grid
  typedef logic [1:0] grid_index_t;

  // Game state
  typedef logic [5:0] score_t;  // Headroom above level-up threshold
  typedef logic [3:0] level_t;

  // Round timer count
  typedef logic [7:0] round_count_t;

  // Round phases of the placer FSM
  typedef enum logic
  {
    play,    // Targets shown, pointer being tracked
    settle   // One-cycle round end, new targets drawn
  } round_phase_t;

endpackage

// File: verilog/target_placer.sv
`timescale 1ns/100ps
`include "mole_macros.svh"

module target_placer
(
  input  logic                 clock,
  input  logic                 reset,
  input  mole_pkg::level_t     level,       // Higher level, shorter round
  output mole_pkg::coord_x_t   target_a_x,
  output mole_pkg::coord_y_t   target_a_y,
  output mole_pkg::coord_x_t   target_b_x,
  output mole_pkg::coord_y_t   target_b_y,
  output logic                 decoy,       // Target b is a penalty decoy
  output logic                 round_end
);

  ////////////////////
  // Random sources
  ////////////////////
  logic [30:0] x_lfsr;
  logic [28:0] y_lfsr;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      x_lfsr <= `LFSR_SEED_X;
      y_lfsr <= `LFSR_SEED_Y;
    end
    else
    begin
      x_lfsr <= {x_lfsr[29:0], x_lfsr[27] ^ x_lfsr[30]};  // Fibonacci, taps 27/30
      y_lfsr <= {y_lfsr[27:0], y_lfsr[26] ^ y_lfsr[28]};  // Taps 26/28
    end
  end

  ////////////////////
  // Round timer
  ////////////////////
  mole_pkg::round_phase_t phase;
  mole_pkg::round_count_t count;
  mole_pkg::round_count_t round_len;

  // Base length halves per level, floored
  always_comb
  begin
    round_len = mole_pkg::round_count_t'(`ROUND_BASE >> level);
    if (round_len < mole_pkg::round_count_t'(`ROUND_MIN))
    begin
      round_len = mole_pkg::round_count_t'(`ROUND_MIN);
    end
  end

  // Play lasts round_len-1 cycles, settle one
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      phase <= mole_pkg::play;
      count <= '0;
    end
    else
    begin
      case (phase)
        mole_pkg::play:
        begin
          if (count == round_len - mole_pkg::round_count_t'(2))
          begin
            phase <= mole_pkg::settle;
          end
          count <= count + 1'b1;
        end
        default:
        begin
          phase <= mole_pkg::play;
          count <= '0;
        end
      endcase
    end
  end

  assign round_end = (phase == mole_pkg::settle);

  ////////////////////
  // Placement
  ////////////////////
  mole_pkg::grid_index_t col_a, row_a;
  mole_pkg::grid_index_t col_b, row_b;
  logic                  same_cell;

  assign col_a = mole_pkg::grid_index_t'(x_lfsr % `GRID_COLS);
  assign row_a = mole_pkg::grid_index_t'(y_lfsr % `GRID_ROWS);
  // Top bit set gives b a cell of its own, otherwise it sits on a
  assign col_b = x_lfsr[30] ? mole_pkg::grid_index_t'(x_lfsr[15:8] % `GRID_COLS) : col_a;
  assign row_b = x_lfsr[30] ? mole_pkg::grid_index_t'(y_lfsr[15:8] % `GRID_ROWS) : row_a;
  assign same_cell = (col_a == col_b) && (row_a == row_b);  // Also catches equal draws

  function automatic mole_pkg::coord_x_t cell_x(input mole_pkg::grid_index_t col);
    return mole_pkg::coord_x_t'(col * `CELL_PITCH + `CELL_OFFSET);
  endfunction

  function automatic mole_pkg::coord_y_t cell_y(input mole_pkg::grid_index_t row);
    return mole_pkg::coord_y_t'(row * `CELL_PITCH + `CELL_OFFSET);
  endfunction

  // New round shows up on the edge closing round_end
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      target_a_x <= cell_x('0);  // Both on cell (0,0)
      target_a_y <= cell_y('0);
      target_b_x <= cell_x('0);
      target_b_y <= cell_y('0);
      decoy      <= 1'b0;
    end
    else if (round_end)
    begin
      target_a_x <= cell_x(col_a);
      target_a_y <= cell_y(row_a);
      target_b_x <= cell_x(col_b);
      target_b_y <= cell_y(row_b);
      decoy      <= x_lfsr[4] && !same_cell;  // Never a decoy on a shared cell
    end
  end

endmodule

// File: verilog/strike_latch.sv
`timescale 1ns/100ps
`include "mole_macros.svh"

module strike_latch
(
  input  logic                clock,
  input  logic                reset,
  input  mole_pkg::coord_x_t  pointer_x,   // Sampled every cycle
  input  mole_pkg::coord_y_t  pointer_y,
  input  mole_pkg::coord_x_t  target_a_x,
  input  mole_pkg::coord_y_t  target_a_y,
  input  mole_pkg::coord_x_t  target_b_x,
  input  mole_pkg::coord_y_t  target_b_y,
  input  logic                round_end,
  output logic                hit_a,
  output logic                hit_b
);

  // Pointer within the square whose corner is (tx, ty)
  function automatic logic in_box
  (
    input mole_pkg::coord_x_t px,
    input mole_pkg::coord_y_t py,
    input mole_pkg::coord_x_t tx,
    input mole_pkg::coord_y_t ty
  );
    return (px >= tx) && (px < tx + `TARGET_SIZE) &&  // 32-bit sum, no wrap
           (py >= ty) && (py < ty + `TARGET_SIZE);
  endfunction

  logic in_a;
  logic in_b;

  assign in_a = in_box(pointer_x, pointer_y, target_a_x, target_a_y);
  assign in_b = in_box(pointer_x, pointer_y, target_b_x, target_b_y);

  ////////////////////
  // Sticky hit flags
  ////////////////////
  always_ff @(posedge clock)
  begin
    if (reset || round_end)
    begin
      // Round over, sample in this cycle dropped
      hit_a <= 1'b0;
      hit_b <= 1'b0;
    end
    else if (in_a)
    begin
      hit_a <= 1'b1;  // a wins where targets overlap
    end
    else if (in_b)
    begin
      hit_b <= 1'b1;
    end
  end

endmodule

// File: verilog/score_keeper.sv
`timescale 1ns/100ps
`include "mole_macros.svh"

module score_keeper
(
  input  logic                clock,
  input  logic                reset,
  input  logic                round_end,   // Strobe from the placer
  input  logic                decoy,
  input  logic                hit_a,
  input  logic                hit_b,
  input  logic                clear,       // Zero the score
  input  mole_pkg::coord_x_t  target_a_x,
  input  mole_pkg::coord_y_t  target_a_y,
  input  mole_pkg::coord_x_t  target_b_x,
  input  mole_pkg::coord_y_t  target_b_y,
  output mole_pkg::score_t    score,
  output mole_pkg::level_t    level
);

  logic             shared;      // Both targets on one cell
  mole_pkg::score_t next_score;

  assign shared = (target_a_x == target_b_x) && (target_a_y == target_b_y);

  ////////////////////
  // Round scoring rules, first match wins
  ////////////////////
  always_comb
  begin
    next_score = score;  // Nothing hit
    if (hit_a && hit_b && !shared && !decoy)
    begin
      next_score = score + mole_pkg::score_t'(`PAIR_REWARD);
    end
    else if ((hit_a && !hit_b) || (!hit_a && hit_b && !decoy) || (hit_a && hit_b && shared))
    begin
      next_score = score + mole_pkg::score_t'(`SINGLE_REWARD);
    end
    else if (hit_a && hit_b && decoy)
    begin
      // Pair with decoy, floored at zero
      if (score >= mole_pkg::score_t'(`DECOY_PAIR_PENALTY))
        next_score = score - mole_pkg::score_t'(`DECOY_PAIR_PENALTY);
      else
        next_score = '0;
    end
    else if (!hit_a && hit_b && decoy)
    begin
      if (score >= mole_pkg::score_t'(`DECOY_PENALTY))  // Decoy alone
        next_score = score - mole_pkg::score_t'(`DECOY_PENALTY);
      else
        next_score = '0;
    end
  end

  // Updates on the edge closing round_end
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      score <= '0;
      level <= '0;
    end
    else if (clear)
    begin
      score <= '0;  // Overrides any round result
    end
    else if (round_end)
    begin
      if (score >= mole_pkg::score_t'(`LEVEL_UP_SCORE))
      begin
        score <= '0;  // Level up instead of scoring
        level <= (level == '1) ? level : level + 1'b1;
      end
      else
      begin
        score <= next_score;
      end
    end
  end

endmodule

// File: verilog/mole_game.sv
`timescale 1ns/100ps

module mole_game
(
  input  logic                clock,
  input  logic                reset,
  input  mole_pkg::coord_x_t  pointer_x,   // Tracked pointer
  input  mole_pkg::coord_y_t  pointer_y,
  input  logic                clear,
  output mole_pkg::coord_x_t  target_a_x,
  output mole_pkg::coord_y_t  target_a_y,
  output mole_pkg::coord_x_t  target_b_x,
  output mole_pkg::coord_y_t  target_b_y,
  output logic                decoy,
  output logic                round_end,
  output mole_pkg::score_t    score,
  output mole_pkg::level_t    level
);

  // Latch to keeper
  logic hit_a;
  logic hit_b;

  ////////////////////
  // Producer, draws targets and times rounds
  target_placer u_placer
  (
    .clock      (clock),
    .reset      (reset),
    .level      (level),       // Fed back from the keeper
    .target_a_x (target_a_x),
    .target_a_y (target_a_y),
    .target_b_x (target_b_x),
    .target_b_y (target_b_y),
    .decoy      (decoy),
    .round_end  (round_end)
  );

  // Buffer, remembers strikes over a round
  strike_latch u_latch
  (
    .clock      (clock),
    .reset      (reset),
    .pointer_x  (pointer_x),
    .pointer_y  (pointer_y),
    .target_a_x (target_a_x),
    .target_a_y (target_a_y),
    .target_b_x (target_b_x),
    .target_b_y (target_b_y),
    .round_end  (round_end),
    .hit_a      (hit_a),
    .hit_b      (hit_b)
  );

  // Consumer
  score_keeper u_keeper
  (
    .clock      (clock),
    .reset      (reset),
    .round_end  (round_end),
    .decoy      (decoy),
    .hit_a      (hit_a),
    .hit_b      (hit_b),
    .clear      (clear),
    .target_a_x (target_a_x),
    .target_a_y (target_a_y),
    .target_b_x (target_b_x),
    .target_b_y (target_b_y),
    .score      (score),
    .level      (level)
  );

endmodule

// File: verification/clock_gen.sv
`timescale 1ns/100ps

module clock_gen
#(
  parameter int half_period  = 10,  // 20 ns clock
  parameter int reset_cycles = 3
)
(
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  // Held over the first rising edges, released on an edge
  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

// File: verification/mole_game_assertions.sv
`timescale 1ns/100ps
`include "mole_macros.svh"

module mole_game_assertions
(
  input logic                clock,
  input logic                reset,
  input logic                round_end,
  input logic                decoy,
  input mole_pkg::coord_x_t  target_a_x,
  input mole_pkg::coord_y_t  target_a_y,
  input mole_pkg::coord_x_t  target_b_x,
  input mole_pkg::coord_y_t  target_b_y,
  input mole_pkg::score_t    score
);

  logic shared_cell;  // Both targets on one cell

  assign shared_cell = (target_a_x == target_b_x) && (target_a_y == target_b_y);

  ////////////////////
  // Strobe is a single cycle
  single_round_end: assert property (@(posedge clock) disable iff (reset)
    round_end |=> !round_end)
    else $error("round_end high on two cycles in a row");

  // No decoy where the targets coincide
  no_shared_decoy: assert property (@(posedge clock) disable iff (reset)
    shared_cell |-> !decoy)
    else $error("decoy raised on a shared cell");

  score_in_range: assert property (@(posedge clock) disable iff (reset)
    score <= mole_pkg::score_t'(`LEVEL_UP_SCORE + `PAIR_REWARD))  // Largest step past threshold
    else $error("score above its ceiling");

endmodule

// File: verification/mole_game_tb.sv
`timescale 1ns/100ps
`include "mole_macros.svh"

module mole_game_tb;

  localparam int sweep_rounds = 12;  // Rounds per random sweep
  // Rounds per test in test order
  localparam int total_rounds = 4 + 2 + 3 * sweep_rounds + 4 + `LEVEL_UP_SCORE + 3;
  localparam int cycle_limit  = (total_rounds + 4) * `ROUND_BASE;  // Level 0 is the longest round

  logic               clock;
  logic               reset;
  mole_pkg::coord_x_t pointer_x;
  mole_pkg::coord_y_t pointer_y;
  logic               clear;
  mole_pkg::coord_x_t target_a_x;
  mole_pkg::coord_y_t target_a_y;
  mole_pkg::coord_x_t target_b_x;
  mole_pkg::coord_y_t target_b_y;
  logic               decoy;
  logic               round_end;
  mole_pkg::score_t   score;
  mole_pkg::level_t   level;

  // Reference model
  mole_pkg::score_t   exp_score;
  mole_pkg::level_t   exp_level;
  int unsigned        lcg_state = 32'd2411;
  int                 cycles = 0;
  int                 decoy_rounds = 0;   // Decoy shown while b was aimed at
  int                 shared_rounds = 0;  // Shared cell while b was aimed at

  clock_gen u_clock_gen
  (
    .clock (clock),
    .reset (reset)
  );

  mole_game u_dut
  (
    .clock      (clock),
    .reset      (reset),
    .pointer_x  (pointer_x),
    .pointer_y  (pointer_y),
    .clear      (clear),
    .target_a_x (target_a_x),
    .target_a_y (target_a_y),
    .target_b_x (target_b_x),
    .target_b_y (target_b_y),
    .decoy      (decoy),
    .round_end  (round_end),
    .score      (score),
    .level      (level)
  );

  bind mole_game mole_game_assertions u_assertions
  (
    .clock      (clock),
    .reset      (reset),
    .round_end  (round_end),
    .decoy      (decoy),
    .target_a_x (target_a_x),
    .target_a_y (target_a_y),
    .target_b_x (target_b_x),
    .target_b_y (target_b_y),
    .score      (score)
  );

  ////////////////////
  // Failure and timeout
  ////////////////////
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  always @(posedge clock)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      abort_run($sformatf("Timeout after %0d cycles, the game did not finish its rounds", cycles));
    end
  end

  task automatic check_score(input mole_pkg::score_t actual, input mole_pkg::score_t expected,
                             input string what);
    if (actual !== expected)
      abort_run($sformatf("Fail at %0d ns: %s score %0d, expected %0d",
                          $time, what, actual, expected));
  endtask

  task automatic check_level(input mole_pkg::level_t actual, input mole_pkg::level_t expected,
                             input string what);
    if (actual !== expected)
      abort_run($sformatf("Fail at %0d ns: %s level %0d, expected %0d",
                          $time, what, actual, expected));
  endtask

  task automatic check_coord_x(input mole_pkg::coord_x_t actual,
                               input mole_pkg::coord_x_t expected, input string what);
    if (actual !== expected)
      abort_run($sformatf("Fail at %0d ns: %s is %0d, expected %0d",
                          $time, what, actual, expected));
  endtask

  task automatic check_coord_y(input mole_pkg::coord_y_t actual,
                               input mole_pkg::coord_y_t expected, input string what);
    if (actual !== expected)
      abort_run($sformatf("Fail at %0d ns: %s is %0d, expected %0d",
                          $time, what, actual, expected));
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected)
      abort_run($sformatf("Fail at %0d ns: %s is %b, expected %b",
                          $time, what, actual, expected));
  endtask

  task automatic check_round_length(input mole_pkg::round_count_t actual,
                                    input mole_pkg::round_count_t expected, input string what);
    if (actual !== expected)
      abort_run($sformatf("Fail at %0d ns: %s %0d cycles, expected %0d",
                          $time, what, actual, expected));
  endtask

  ////////////////////
  // Model helpers
  ////////////////////
  function automatic int next_offset();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'((lcg_state >> 16) % `TARGET_SIZE);  // Upper bits spread better
  endfunction

  // Nearest legal cell corner
  // Equals the input only for a coordinate on the grid
  function automatic int snap_to_grid(input int pos, input int cells);
    int idx;
    idx = (pos - `CELL_OFFSET) / `CELL_PITCH;
    if (idx < 0)
      idx = 0;
    if (idx > cells - 1)
      idx = cells - 1;
    return idx * `CELL_PITCH + `CELL_OFFSET;
  endfunction

  function automatic int round_length(input mole_pkg::level_t lvl);
    int len;
    len = `ROUND_BASE >> lvl;
    if (len < `ROUND_MIN)
      len = `ROUND_MIN;  // Floor at high levels
    return len;
  endfunction

  // Scoring rules at one round end
  task automatic score_round(input logic ha, input logic hb, input logic shared, input logic dec);
    int s;
    s = int'(exp_score);
    if (exp_score >= mole_pkg::score_t'(`LEVEL_UP_SCORE))
    begin
      s = 0;  // Level up replaces scoring
      if (exp_level != mole_pkg::level_t'(15))
        exp_level = exp_level + mole_pkg::level_t'(1);
    end
    else if (ha && hb && !shared && !dec)
      s = s + `PAIR_REWARD;
    else if ((ha && !hb) || (hb && !ha && !dec) || (ha && hb && shared))
      s = s + `SINGLE_REWARD;
    else if (ha && hb && dec)
      s = (s > `DECOY_PAIR_PENALTY) ? s - `DECOY_PAIR_PENALTY : 0;
    else if (hb && dec)
      s = (s > `DECOY_PENALTY) ? s - `DECOY_PENALTY : 0;
    exp_score = mole_pkg::score_t'(s);
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////
  task automatic aim_at(input mole_pkg::coord_x_t tx, input mole_pkg::coord_y_t ty);
    int dx;
    int dy;
    dx = next_offset();
    dy = next_offset();
    @(posedge clock);
    pointer_x <= tx + mole_pkg::coord_x_t'(dx);
    pointer_y <= ty + mole_pkg::coord_y_t'(dy);
  endtask

  task automatic park_pointer();
    @(posedge clock);
    pointer_x <= '0;  // Left of and above every cell
    pointer_y <= '0;
  endtask

  task automatic wait_round_end();
    do
      @(negedge clock);
    while (round_end !== 1'b1);
  endtask

  task automatic clear_score();
    @(posedge clock);
    clear <= 1'b1;
    @(posedge clock);
    clear <= 1'b0;
    @(negedge clock);
    exp_score = '0;
    check_score(score, exp_score, "after clear");
  endtask

  // Plays one round and returns in the first cycle of the next
  task automatic play_round(input logic aim_a, input logic aim_b);
    logic shared;
    shared = (target_a_x == target_b_x) && (target_a_y == target_b_y);
    check_coord_x(target_a_x, mole_pkg::coord_x_t'(snap_to_grid(int'(target_a_x), `GRID_COLS)),
                  "target a x");
    check_coord_y(target_a_y, mole_pkg::coord_y_t'(snap_to_grid(int'(target_a_y), `GRID_ROWS)),
                  "target a y");
    check_coord_x(target_b_x, mole_pkg::coord_x_t'(snap_to_grid(int'(target_b_x), `GRID_COLS)),
                  "target b x");
    check_coord_y(target_b_y, mole_pkg::coord_y_t'(snap_to_grid(int'(target_b_y), `GRID_ROWS)),
                  "target b y");
    if (shared)
    begin
      check_bit(decoy, 1'b0, "decoy on shared cell");
      if (aim_b)
        shared_rounds++;
    end
    if (decoy && aim_b)
      decoy_rounds++;
    if (aim_a)
      aim_at(target_a_x, target_a_y);
    if (aim_b)
      aim_at(target_b_x, target_b_y);
    park_pointer();
    wait_round_end();
    // On a shared cell the pointer always lands in a first
    score_round(aim_a || (aim_b && shared), aim_b && !shared, shared, decoy);
    @(negedge clock);
    check_score(score, exp_score, "round end");
    check_level(level, exp_level, "round end");
  endtask

  // Spacing between two round_end pulses with the pointer parked
  task automatic measure_period();
    int period;
    wait_round_end();
    score_round(1'b0, 1'b0, 1'b0, 1'b0);
    period = 0;
    do
    begin
      @(negedge clock);
      period++;
    end
    while (round_end !== 1'b1);
    check_round_length(mole_pkg::round_count_t'(period),
                       mole_pkg::round_count_t'(round_length(exp_level)), "round_end spacing");
    score_round(1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge clock);
    check_score(score, exp_score, "after idle rounds");
    check_level(level, exp_level, "after idle rounds");
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic test_reset_state();
    check_score(score, '0, "after reset");
    check_level(level, '0, "after reset");
    check_bit(round_end, 1'b0, "round_end after reset");
    check_bit(decoy, 1'b0, "decoy after reset");
    check_coord_x(target_a_x, mole_pkg::coord_x_t'(`CELL_OFFSET), "target a x after reset");
    check_coord_y(target_a_y, mole_pkg::coord_y_t'(`CELL_OFFSET), "target a y after reset");
    check_coord_x(target_b_x, mole_pkg::coord_x_t'(`CELL_OFFSET), "target b x after reset");
    check_coord_y(target_b_y, mole_pkg::coord_y_t'(`CELL_OFFSET), "target b y after reset");
    measure_period();
    repeat (2) play_round(1'b0, 1'b0);  // Grid checks on fresh placements
  endtask

  task automatic test_single_and_idle();
    play_round(1'b1, 1'b0);
    play_round(1'b0, 1'b0);
  endtask

  task automatic test_pairs();
    clear_score();
    repeat (sweep_rounds) play_round(1'b1, 1'b1);
  endtask

  task automatic test_b_only();
    repeat (sweep_rounds)
    begin
      play_round(1'b1, 1'b0);  // Headroom for the penalty
      play_round(1'b0, 1'b1);
    end
  endtask

  task automatic test_clear();
    play_round(1'b1, 1'b0);
    clear_score();  // Mid-round
    play_round(1'b0, 1'b0);
    play_round(1'b1, 1'b0);
    aim_at(target_a_x, target_a_y);  // Hit that clear must override
    park_pointer();
    repeat (round_length(exp_level) - 4) @(posedge clock);
    @(posedge clock);
    clear <= 1'b1;  // Lands in the round_end cycle
    @(negedge clock);
    check_bit(round_end, 1'b1, "round_end under clear");
    @(posedge clock);
    clear <= 1'b0;
    @(negedge clock);
    exp_score = '0;
    check_score(score, exp_score, "clear at round end");
    check_level(level, exp_level, "clear at round end");
  endtask

  task automatic test_level_up();
    clear_score();
    while (exp_score < mole_pkg::score_t'(`LEVEL_UP_SCORE))
      play_round(1'b1, 1'b0);
    play_round(1'b0, 1'b0);  // Level rises at this round end
    measure_period();
  endtask

  initial
  begin
    pointer_x <= '0;
    pointer_y <= '0;
    clear     <= 1'b0;
    exp_score = '0;
    exp_level = '0;
    wait (reset == 1'b0);
    @(negedge clock);  // First cycle of the first round
    test_reset_state();
    test_single_and_idle();
    test_pairs();
    test_b_only();
    test_clear();
    test_level_up();
    if (decoy_rounds == 0)
      abort_run("No decoy appeared in a round that aimed at target b");
    else if (shared_rounds == 0)
      abort_run("No shared cell appeared in a round that aimed at target b");
    else
    begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// File: compile.f
+incdir+verilog
verilog/mole_pkg.sv
verilog/target_placer.sv
verilog/strike_latch.sv
verilog/score_keeper.sv
verilog/mole_game.sv
verification/clock_gen.sv
verification/mole_game_assertions.sv
verification/mole_game_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := mole_game_tb
FILELIST := compile.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verilog/mole_macros.svh

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

$(LOG): $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)

run: $(LOG)

check: $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
